// ==== src/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// fixed-point word, 4 integer bits and 16 fraction bits
`define DATA_W 20
`define FRAC_W 16

// image side is 1 << IMG_LOG2
`define IMG_LOG2 2

// 3x3 window
`define TAPS 9

// radix-4 digits needed for a 16-bit unsigned multiplier
`define BOOTH_STEPS 9

`endif

// ==== src/fixPkg.sv ====
`default_nettype none

`include "conv_cfg.svh"

package fixPkg;

    // signed 4.16 word
    typedef logic signed [`DATA_W-1:0] fixT;

    // magnitude product of two 16-bit fractions
    typedef logic [2*`FRAC_W-1:0] prodT;

    // radix-4 Booth digit
    typedef enum logic [2:0] {
        DIG_ZERO,
        DIG_PLUS1,
        DIG_PLUS2,
        DIG_MINUS1,
        DIG_MINUS2
    } boothDigitT;

endpackage

`default_nettype wire

// ==== src/convPkg.sv ====
`default_nettype none

`include "conv_cfg.svh"

package convPkg;

    // pixel coordinate, wraps modulo the image side
    typedef struct packed {
        logic [`IMG_LOG2-1:0] row;
        logic [`IMG_LOG2-1:0] col;
    } pixAddrT;

    // one tap of the window as seen by the channels
    typedef struct packed {
        logic [3:0] tapIdx; // 0..8, row major inside the window
        logic       pad;    // tap lies outside the image
        logic       last;   // tap 8
    } tapCmdT;

    // one output record
    typedef struct packed {
        pixAddrT    wrAddr; // window centre
        fixPkg::fixT value0;
        fixPkg::fixT value1;
    } convResultT;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_FETCH, // address on the bus
        SCAN_LOAD,  // pixel returned, tap strobe
        SCAN_MULT,  // waiting for the product to be added
        SCAN_DONE   // all taps added, waiting for the result
    } scanStateT;

endpackage

`default_nettype wire

// ==== src/boothMult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module boothMult (
    input  logic        clk,
    input  logic        reset,
    input  logic        go,           // operands valid this cycle
    input  fixPkg::fixT multiplicand,
    input  fixPkg::fixT multiplier,
    output fixPkg::fixT product,
    output logic        done          // product valid, one cycle
);

    fixPkg::fixT absCand;
    fixPkg::fixT absPlier;
    logic [`FRAC_W-1:0] mc;          // magnitude of multiplicand
    logic [`FRAC_W-1:0] mp;          // magnitude of multiplier
    logic [`FRAC_W+2:0] mpExt;       // mp with the implicit zero below bit 0
    logic               negProd;
    logic               busy;
    logic [3:0]         step;
    logic [2:0]         group;
    fixPkg::boothDigitT digit;
    logic [`FRAC_W+1:0] pp;          // signed partial product, up to +-2*mc
    logic [`FRAC_W+4:0] rowBits;     // pp with the sign extension bits
    fixPkg::prodT       rowTerm;
    fixPkg::prodT       acc;
    fixPkg::prodT       accNext;
    logic [`FRAC_W-1:0] mag;
    fixPkg::fixT        magWord;

    function automatic fixPkg::boothDigitT boothDecode(input logic [2:0] bits);
        case (bits)
            3'b001, 3'b010: boothDecode = fixPkg::DIG_PLUS1;
            3'b011:         boothDecode = fixPkg::DIG_PLUS2;
            3'b100:         boothDecode = fixPkg::DIG_MINUS2;
            3'b101, 3'b110: boothDecode = fixPkg::DIG_MINUS1;
            default:        boothDecode = fixPkg::DIG_ZERO; // 000 and 111
        endcase
    endfunction

    assign absCand  = multiplicand[`DATA_W-1] ? -multiplicand : multiplicand;
    assign absPlier = multiplier[`DATA_W-1] ? -multiplier : multiplier;

    assign mpExt = {2'b00, mp, 1'b0};
    assign group = mpExt[{step, 1'b0} +: 3];
    assign digit = boothDecode(group);

    always_comb begin
        case (digit)
            fixPkg::DIG_PLUS1:  pp = {2'b00, mc};
            fixPkg::DIG_PLUS2:  pp = {1'b0, mc, 1'b0};
            fixPkg::DIG_MINUS1: pp = -{2'b00, mc};
            fixPkg::DIG_MINUS2: pp = -{1'b0, mc, 1'b0};
            default:            pp = '0;
        endcase

        // constant ones replace the full sign extension, they cancel mod 2^32
        if (step == 4'd0) begin
            rowBits = {~pp[`FRAC_W+1], pp[`FRAC_W+1], pp[`FRAC_W+1], pp};
        end else if (step == 4'(`BOOTH_STEPS - 1)) begin
            rowBits = {3'b000, pp}; // top digit is never negative
        end else begin
            rowBits = {1'b0, 1'b1, ~pp[`FRAC_W+1], pp};
        end
        rowTerm = fixPkg::prodT'(rowBits) << {step, 1'b0};
        accNext = acc + rowTerm;
    end

    // round at bit 15 then restore the sign
    assign mag = accNext[2*`FRAC_W-1:`FRAC_W] + {{(`FRAC_W-1){1'b0}}, accNext[`FRAC_W-1]};
    assign magWord = {{(`DATA_W-`FRAC_W){1'b0}}, mag};

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
            step <= 4'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                step <= 4'd0;
            end else if (busy) begin
                step <= step + 4'd1;
                if (step == 4'(`BOOTH_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            mc      <= absCand[`FRAC_W-1:0]; // operands are below one in magnitude
            mp      <= absPlier[`FRAC_W-1:0];
            negProd <= multiplicand[`DATA_W-1] ^ multiplier[`DATA_W-1];
            acc     <= '0;
        end else if (busy) begin
            acc <= accNext;
        end
        if (busy && step == 4'(`BOOTH_STEPS - 1)) begin
            product <= negProd ? -magWord : magWord;
        end
    end

endmodule

`default_nettype wire

// ==== src/windowScan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module windowScan (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             tapDone,
    input  logic             windowDone,
    output convPkg::pixAddrT pixAddr,
    output convPkg::pixAddrT wrAddr,
    output logic             tapStrobe,
    output convPkg::tapCmdT  tapCmd,
    output logic             frameDone
);

    // all ones is the last pixel, and -1 when it sits in the corner
    localparam logic [`IMG_LOG2-1:0] LAST_IDX  = '1;
    localparam logic [`IMG_LOG2-1:0] NEAR_EDGE = LAST_IDX - 1'b1;

    convPkg::scanStateT state;
    convPkg::pixAddrT   corner;     // upper left of the window
    convPkg::pixAddrT   center;
    convPkg::pixAddrT   nextCenter;
    convPkg::pixAddrT   nextCorner;
    logic [3:0]         tapIdx;
    logic [1:0]         rowOff;
    logic [1:0]         colOff;
    logic               padRow;
    logic               padCol;
    logic               lastWindow;

    always_comb begin
        case (tapIdx)
            4'd0, 4'd1, 4'd2: rowOff = 2'd0;
            4'd3, 4'd4, 4'd5: rowOff = 2'd1;
            default:          rowOff = 2'd2;
        endcase
        case (tapIdx)
            4'd0, 4'd3, 4'd6: colOff = 2'd0;
            4'd1, 4'd4, 4'd7: colOff = 2'd1;
            default:          colOff = 2'd2;
        endcase
    end

    // read address wraps; padded taps still read, the pixel gets dropped
    assign pixAddr.row = corner.row + `IMG_LOG2'(rowOff);
    assign pixAddr.col = corner.col + `IMG_LOG2'(colOff);

    assign padRow = (corner.row == LAST_IDX && rowOff == 2'd0) ||
                    (corner.row == NEAR_EDGE && rowOff == 2'd2);
    assign padCol = (corner.col == LAST_IDX && colOff == 2'd0) ||
                    (corner.col == NEAR_EDGE && colOff == 2'd2);

    assign tapCmd.tapIdx = tapIdx;
    assign tapCmd.pad    = padRow | padCol;
    assign tapCmd.last   = (tapIdx == 4'(`TAPS - 1));
    assign tapStrobe     = (state == convPkg::SCAN_LOAD); // pixData holds the tap now

    assign center.row = corner.row + 1'b1;
    assign center.col = corner.col + 1'b1;
    assign wrAddr     = center;
    assign lastWindow = (center.row == LAST_IDX) && (center.col == LAST_IDX);

    // zigzag through 2x2 blocks, row pairs left to right
    always_comb begin
        nextCenter = center;
        if (!center.col[0]) begin
            nextCenter.col = center.col + 1'b1;            // left to right in the block
        end else if (!center.row[0]) begin
            nextCenter.row = center.row + 1'b1;            // down to the lower left
            nextCenter.col = center.col - 1'b1;
        end else begin
            nextCenter.col = center.col + 1'b1;            // wraps to 0 at the right edge
            if (center.col == LAST_IDX) begin
                nextCenter.row = center.row + 1'b1;        // next row pair
            end else begin
                nextCenter.row = center.row - 1'b1;        // next block, same row pair
            end
        end
        nextCorner.row = nextCenter.row - 1'b1;
        nextCorner.col = nextCenter.col - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= convPkg::SCAN_IDLE;
            corner    <= '1;              // row -1, col -1
            tapIdx    <= 4'd0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                convPkg::SCAN_IDLE: begin
                    if (start) begin
                        tapIdx <= 4'd0;
                        state  <= convPkg::SCAN_FETCH;
                    end
                end
                convPkg::SCAN_FETCH: state <= convPkg::SCAN_LOAD;  // memory latency
                convPkg::SCAN_LOAD:  state <= convPkg::SCAN_MULT;
                convPkg::SCAN_MULT: begin
                    if (tapDone) begin
                        if (tapCmd.last) begin
                            state <= convPkg::SCAN_DONE;
                        end else begin
                            tapIdx <= tapIdx + 4'd1;
                            state  <= convPkg::SCAN_FETCH;
                        end
                    end
                end
                convPkg::SCAN_DONE: begin
                    if (windowDone) begin
                        tapIdx <= 4'd0;
                        if (lastWindow) begin
                            corner    <= '1;      // ready for the next frame
                            frameDone <= 1'b1;
                            state     <= convPkg::SCAN_IDLE;
                        end else begin
                            corner <= nextCorner;
                            state  <= convPkg::SCAN_FETCH;
                        end
                    end
                end
                default: state <= convPkg::SCAN_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/convChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module convChannel #(
    parameter int CHANNEL = 0 // selects kernel and bias
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            tapStrobe,
    input  convPkg::tapCmdT tapCmd,
    input  fixPkg::fixT     pixData,
    output logic            tapDone,
    output fixPkg::fixT     value,
    output logic            resultValid
);

    // 3x3 kernels, row major
    localparam fixPkg::fixT WEIGHTS [0:1][0:`TAPS-1] = '{
        '{20'h0A89E, 20'h092D5, 20'h06D43,
          20'h01004, 20'hF8F71, 20'hF6E54,
          20'hFA6D7, 20'hFC834, 20'hFAC19},
        '{20'hFDB55, 20'h02992, 20'hFC994,
          20'h050FD, 20'h02F20, 20'h0202D,
          20'h03BD7, 20'hFD369, 20'h05E68}
    };
    localparam fixPkg::fixT BIAS [0:1] = '{20'h01310, 20'hF7295};

    fixPkg::fixT tapPixel;
    fixPkg::fixT tapWeight;
    fixPkg::fixT multProduct;
    fixPkg::fixT sum;
    fixPkg::fixT biased;
    logic        multDone;
    logic        lastTap;  // the product in flight belongs to tap 8

    assign tapPixel  = tapCmd.pad ? '0 : pixData; // zero padding
    assign tapWeight = (tapCmd.tapIdx < 4'(`TAPS)) ? WEIGHTS[CHANNEL][tapCmd.tapIdx] : '0;

    boothMult i_boothMult (
        .clk         (clk),
        .reset       (reset),
        .go          (tapStrobe),
        .multiplicand(tapPixel),
        .multiplier  (tapWeight),
        .product     (multProduct),
        .done        (multDone)
    );

    // the product is added in the cycle it arrives
    assign tapDone = multDone;
    assign biased  = sum + multProduct + BIAS[CHANNEL];

    always_ff @(posedge clk) begin
        if (!reset) begin
            lastTap     <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= multDone & lastTap; // one cycle after the last tapDone
            if (tapStrobe) begin
                lastTap <= tapCmd.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tapStrobe && tapCmd.tapIdx == 4'd0) begin
            sum <= '0;                          // new window
        end else if (multDone) begin
            sum <= sum + multProduct;
        end
        if (multDone && lastTap) begin
            value <= biased[`DATA_W-1] ? '0 : biased; // ReLU
        end
    end

endmodule

`default_nettype wire

// ==== src/convLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module convLayer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  fixPkg::fixT         pixData,
    output convPkg::pixAddrT    pixAddr,
    output logic                resultValid,
    output convPkg::convResultT result,
    output logic                frameDone
);

    logic             tapStrobe;
    logic             tapDone;   // from channel 0, both run in lock step
    convPkg::tapCmdT  tapCmd;
    convPkg::pixAddrT wrAddr;
    fixPkg::fixT      value0;
    fixPkg::fixT      value1;

    windowScan i_windowScan (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .tapDone   (tapDone),
        .windowDone(resultValid),
        .pixAddr   (pixAddr),
        .wrAddr    (wrAddr),
        .tapStrobe (tapStrobe),
        .tapCmd    (tapCmd),
        .frameDone (frameDone)
    );

    convChannel #(.CHANNEL(0)) i_convChannel0 (
        .clk        (clk),
        .reset      (reset),
        .tapStrobe  (tapStrobe),
        .tapCmd     (tapCmd),
        .pixData    (pixData),
        .tapDone    (tapDone),
        .value      (value0),
        .resultValid(resultValid)
    );

    convChannel #(.CHANNEL(1)) i_convChannel1 (
        .clk        (clk),
        .reset      (reset),
        .tapStrobe  (tapStrobe),
        .tapCmd     (tapCmd),
        .pixData    (pixData),
        .tapDone    (),
        .value      (value1),
        .resultValid()
    );

    assign result.wrAddr = wrAddr;
    assign result.value0 = value0;
    assign result.value1 = value1;

endmodule

`default_nettype wire

// ==== verif/convLayer_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module convLayer_properties (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                resultValid,
    input wire logic                frameDone,
    input wire logic                tapStrobe,
    input wire convPkg::scanStateT  scanState,
    input wire convPkg::convResultT result
);

    // strobes last exactly one cycle
    resultPulse: assert property (@(posedge clk) disable iff (!reset)
        resultValid |=> !resultValid)
        else $error("resultValid high in two cycles in a row");

    framePulse: assert property (@(posedge clk) disable iff (!reset)
        frameDone |=> !frameDone)
        else $error("frameDone high in two cycles in a row");

    // no tap while the scan sits idle
    tapWhileIdle: assert property (@(posedge clk) disable iff (!reset)
        tapStrobe |-> scanState != convPkg::SCAN_IDLE)
        else $error("tapStrobe while the scan is idle");

    reluSign: assert property (@(posedge clk) disable iff (!reset)
        resultValid |-> !result.value0[`DATA_W-1] && !result.value1[`DATA_W-1])
        else $error("negative value after ReLU");

endmodule

`default_nettype wire

// ==== verif/convChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module convChecker (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire convPkg::pixAddrT    pixAddr,
    input  wire logic                resultValid,
    input  wire convPkg::convResultT result,
    input  wire logic                frameDone,
    output int                       errorCount,
    output int                       framesChecked
);

    localparam int WINDOWS = 1 << (2 * `IMG_LOG2);
    localparam int FRAMES  = 2;

    logic [`DATA_W-1:0] golden [0:4*WINDOWS-1]; // pixels followed by 3 words per window
    logic               inFrame;
    logic               idleChecked;
    int                 resultIdx;
    int                 testErrors;
    int                 testsRun;
    int                 testsFailed;

    initial begin
        $readmemh("verif/conv_golden.txt", golden);
        inFrame       = 1'b0;
        idleChecked   = 1'b0;
        resultIdx     = 0;
        testErrors    = 0;
        testsRun      = 0;
        testsFailed   = 0;
        errorCount    = 0;
        framesChecked = 0;
    end

    // within one step of the centre modulo the image side
    function automatic logic nearCentre(input logic [`IMG_LOG2-1:0] a,
                                        input logic [`IMG_LOG2-1:0] c);
        logic [`IMG_LOG2-1:0] d;
        d = a - c;
        return (d == 0) || (d == 1) || (d == '1);
    endfunction

    // per-test count for the report line, running total for the verdict
    task automatic countError();
        testErrors++;
        errorCount++;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors > 0) testsFailed++;
        $display("test %0d %s: %s, %0d errors", testsRun, name,
                 (testErrors > 0) ? "FAILED" : "ok", testErrors);
        testErrors = 0;
    endtask

    task automatic compareWord(input string what, input logic [`DATA_W-1:0] got,
                               input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: window %0d %s got %h expected %h",
                     $time, resultIdx, what, got, exp);
            countError();
        end
    endtask

    always @(posedge clk) begin
        logic [`DATA_W-1:0] expAddr;
        int base;
        if (reset) begin
            if (start && !inFrame) begin
                if (!idleChecked) begin
                    idleChecked = 1'b1;
                    finishTest("idle after reset");  // no strobes before the first start
                end
                inFrame   = 1'b1;
                resultIdx = 0;
            end
            base    = WINDOWS + 3 * resultIdx;
            expAddr = (resultIdx < WINDOWS) ? golden[base] : '0;
            // read window follows the window in progress
            if (inFrame && resultIdx < WINDOWS && !start) begin
                if (!nearCentre(pixAddr.row, expAddr[2*`IMG_LOG2-1:`IMG_LOG2]) ||
                    !nearCentre(pixAddr.col, expAddr[`IMG_LOG2-1:0])) begin
                    $display("read address %0d,%0d lies outside window %0d at %0t ns",
                             pixAddr.row, pixAddr.col, resultIdx, $time);
                    countError();
                end
            end
            if (resultValid) begin
                if (!inFrame) begin
                    $display("result strobe outside a frame at %0t ns", $time);
                    countError();
                end else if (resultIdx >= WINDOWS) begin
                    $display("more than %0d results in one frame at %0t ns", WINDOWS, $time);
                    countError();
                end else begin
                    compareWord("wrAddr", `DATA_W'(result.wrAddr), expAddr);
                    compareWord("value0", result.value0, golden[base+1]);
                    compareWord("value1", result.value1, golden[base+2]);
                    if (result.value0[`DATA_W-1] || result.value1[`DATA_W-1]) begin
                        $display("negative result after ReLU at %0t ns", $time);
                        countError();
                    end
                    resultIdx++;
                end
            end
            if (frameDone) begin
                if (!inFrame) begin
                    $display("frame done without a running frame at %0t ns", $time);
                    countError();
                end else if (resultIdx != WINDOWS) begin
                    $display("frame ended after %0d results instead of %0d",
                             resultIdx, WINDOWS);
                    countError();
                end
                inFrame = 1'b0;
                framesChecked++;
                finishTest($sformatf("frame %0d", framesChecked));
                if (framesChecked == FRAMES) begin
                    $display("summary: %0d tests, %0d failed, %0d errors",
                             testsRun, testsFailed, errorCount);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/convLayer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module convLayer_tb;

    localparam int     CLK_HALF   = 20;
    localparam int     FRAMES     = 2;
    localparam int     WINDOWS    = 1 << (2 * `IMG_LOG2);
    localparam int     TAP_CYCLES = 12;
    // every tap of every window of both frames, doubled
    localparam longint WATCHDOG_NS =
        longint'(FRAMES) * WINDOWS * `TAPS * TAP_CYCLES * 2 * CLK_HALF * 2;

    logic                clk;
    logic                reset;
    logic                start;
    fixPkg::fixT         pixData;
    convPkg::pixAddrT    pixAddr;
    logic                resultValid;
    logic                frameDone;
    convPkg::convResultT result;
    logic [`DATA_W-1:0]  golden [0:4*WINDOWS-1]; // first WINDOWS words are the image
    int                  errorCount;
    int                  framesChecked;

    convLayer i_convLayer (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .pixData    (pixData),
        .pixAddr    (pixAddr),
        .resultValid(resultValid),
        .result     (result),
        .frameDone  (frameDone)
    );

    convChecker i_convChecker (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .pixAddr      (pixAddr),
        .resultValid  (resultValid),
        .result       (result),
        .frameDone    (frameDone),
        .errorCount   (errorCount),
        .framesChecked(framesChecked)
    );

    bind convLayer convLayer_properties i_properties (
        .clk        (clk),
        .reset      (reset),
        .resultValid(resultValid),
        .frameDone  (frameDone),
        .tapStrobe  (tapStrobe),
        .scanState  (i_windowScan.state),
        .result     (result)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // image memory, one cycle latency
    always @(posedge clk) begin
        pixData <= golden[{pixAddr.row, pixAddr.col}];
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the frames did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset   = 1'b0;
        start   = 1'b0;
        pixData = '0;
        $readmemh("verif/conv_golden.txt", golden);
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);    // idle, no strobes expected
        for (int f = 0; f < FRAMES; f++) begin
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            do @(posedge clk); while (!frameDone);
            repeat (3) @(posedge clk);
        end
        if (errorCount == 0 && framesChecked == FRAMES) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/conv_golden.txt ====
// pixels 0..15 row major as 4.16 hex, then per window in output order:
// centre address (row*4+col), value0, value1
0C000 0C000 0C000 0C000
0C000 0C000 0C000 0C000
0C000 0C000 0C000 0C000
F4000 F4000 F4000 F4000
0 00000 00000
1 00000 03D0B
4 00000 00000
5 00000 017E8
2 00000 03D0B
3 00000 00000
6 00000 017E8
7 04A87 00000
8 07A3C 00000
9 14795 00000
C 194CE 00000
D 20742 00000
A 14795 00000
B 123F7 00000
E 20742 00000
F 1480F 00000

// ==== tb.f ====
+incdir+src
src/fixPkg.sv
src/convPkg.sv
src/boothMult.sv
src/windowScan.sv
src/convChannel.sv
src/convLayer.sv
verif/convLayer_properties.sv
verif/convChecker.sv
verif/convLayer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= convLayer_tb
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
